// File: hw/ncpu_pkg.sv
// Shared widths, MSR address map, interrupt numbering and TCR layout
`default_nettype none

package ncpu_pkg;

   // Data path width of the CPU
   localparam int NCPU_DW = 32;

   // Width of the compare field in TCR
   // and of the low TSR slice it is matched against
   localparam int TSC_CNT_DW = 24;

   // MSR address width
   localparam int MSR_AW = 4;

   // MSR address map, anything else is unmapped
   localparam logic [MSR_AW-1:0] MSR_TSR = 4'd0;
   localparam logic [MSR_AW-1:0] MSR_TCR = 4'd1;
   localparam logic [MSR_AW-1:0] MSR_IMR = 4'd2;
   // Read only
   localparam logic [MSR_AW-1:0] MSR_IRR = 4'd3;

   // Total interrupt lines seen by IMR and IRR
   localparam int NIRQ = 8;

   // Line of the timestamp counter interrupt
   localparam int IRQ_TSC = 0;

   // External level lines sit above the TSC line
   localparam int NEXT_IRQ = 7;

   // TCR field layout, MSB first
   typedef struct packed {
      // Reads back as zero
      logic [3:0]            rsvd;
      // Spare bit, stored and read back
      logic                  rb1;
      // Pending, live interrupt flag on read
      logic                  p;
      // Interrupt enable
      logic                  i;
      // Count enable
      logic                  en;
      // Compare value
      logic [TSC_CNT_DW-1:0] cnt;
   } tcr_fields_t;

   // TCR as seen on the bus and as decoded fields
   typedef union packed {
      logic [NCPU_DW-1:0] raw;
      tcr_fields_t        f;
   } tcr_u;

endpackage

`default_nettype wire

// File: hw/msr_port.sv
// MSR access slave: four-phase handshake, address decode, write strobes, read mux
`timescale 1ns/1ps
`default_nettype none

module msr_port
   import ncpu_pkg::*;
(
   input  logic               clk,
   input  logic               rst,
   // CPU side
   input  logic               req,
   input  logic               we,
   input  logic [MSR_AW-1:0]  addr,
   input  logic [NCPU_DW-1:0] wdata,
   output logic               ack,
   output logic [NCPU_DW-1:0] rdata,
   // Register side
   output logic [NCPU_DW-1:0] wr_data,
   output logic               tsr_we,
   output logic               tcr_we,
   output logic               imr_we,
   input  logic [NCPU_DW-1:0] tsr_rd,
   input  logic [NCPU_DW-1:0] tcr_rd,
   input  logic [NCPU_DW-1:0] imr_rd,
   input  logic [NIRQ-1:0]    irr_rd
);

   // Handshake state, low is idle
   logic               busy;

   // Access latched at the start of a transfer
   logic [MSR_AW-1:0]  addr_r;
   logic               we_r;
   logic [NCPU_DW-1:0] wdata_r;

   // First busy cycle, strobes fire here
   logic               access;
   logic [NCPU_DW-1:0] rd_mux;

   // Idle -> busy on req
   // busy, ack low: strobe cycle, ack rises at its end
   // busy, ack high: hold until the CPU drops req
   always_ff @(posedge clk) begin
      if (rst) begin
         busy <= 1'b0;
         ack  <= 1'b0;
      end else if (!busy) begin
         if (req) begin
            busy <= 1'b1;
         end
      end else if (!ack) begin
         ack <= 1'b1;
      end else if (!req) begin
         // Release, ack falls at the first edge with req low
         ack  <= 1'b0;
         busy <= 1'b0;
      end
   end

   // Latch the request in idle
   always_ff @(posedge clk) begin
      if (!busy && req) begin
         addr_r  <= addr;
         we_r    <= we;
         wdata_r <= wdata;
      end
   end

   assign access  = busy & ~ack;
   // One data bus shared by every target
   assign wr_data = wdata_r;

   // Write strobe decode
   // IRR and unmapped addresses get no strobe
   always_comb begin
      tsr_we = 1'b0;
      tcr_we = 1'b0;
      imr_we = 1'b0;
      if (access && we_r) begin
         case (addr_r)
            MSR_TSR: tsr_we = 1'b1;
            MSR_TCR: tcr_we = 1'b1;
            MSR_IMR: imr_we = 1'b1;
            default: ;
         endcase
      end
   end

   // Read source select
   always_comb begin
      case (addr_r)
         MSR_TSR: rd_mux = tsr_rd;
         MSR_TCR: rd_mux = tcr_rd;
         MSR_IMR: rd_mux = imr_rd;
         // IRR is narrower than the bus
         MSR_IRR: rd_mux = {{(NCPU_DW-NIRQ){1'b0}}, irr_rd};
         // Unmapped reads return zero
         default: rd_mux = '0;
      endcase
   end

   // Capture read data together with ack rising
   // held stable while ack stays high
   always_ff @(posedge clk) begin
      if (access) begin
         rdata <= rd_mux;
      end
   end

endmodule

`default_nettype wire

// File: hw/tsc.sv
// Timestamp counter: TSR, TCR register, compare match and TSC interrupt flag
`timescale 1ns/1ps
`default_nettype none

module tsc
   import ncpu_pkg::*;
(
   input  logic               clk,
   input  logic               rst,
   input  logic               tsr_we,
   input  logic               tcr_we,
   input  logic [NCPU_DW-1:0] wr_data,
   output logic [NCPU_DW-1:0] tsr_rd,
   output logic [NCPU_DW-1:0] tcr_rd,
   output logic               tsc_irq
);

   // Stored TCR
   tcr_u  tcr_r;
   // Incoming TCR write, decoded as fields
   tcr_u  tcr_wr;
   // Read view, also the live control word
   tcr_u  tcr_view;

   logic  irq_set;
   logic  irq_clr;

   assign tcr_wr.raw = wr_data;

   // TCR storage
   always_ff @(posedge clk) begin
      if (rst) begin
         tcr_r.raw <= '0;
      end else if (tcr_we) begin
         tcr_r.raw <= wr_data;
      end
   end

   // Pack the view
   // a write in flight bypasses the stored word so its fields act at once
   always_comb begin
      tcr_view.f.rsvd = '0;
      if (tcr_we) begin
         tcr_view.f.rb1 = tcr_wr.f.rb1;
         tcr_view.f.p   = tcr_wr.f.p;
         tcr_view.f.i   = tcr_wr.f.i;
         tcr_view.f.en  = tcr_wr.f.en;
         tcr_view.f.cnt = tcr_wr.f.cnt;
      end else begin
         tcr_view.f.rb1 = tcr_r.f.rb1;
         // Pending is the live flag, not the stored bit
         tcr_view.f.p   = tsc_irq;
         tcr_view.f.i   = tcr_r.f.i;
         tcr_view.f.en  = tcr_r.f.en;
         tcr_view.f.cnt = tcr_r.f.cnt;
      end
   end

   assign tcr_rd = tcr_view.raw;

   // Counter, software write beats the increment
   always_ff @(posedge clk) begin
      if (rst) begin
         tsr_rd <= '0;
      end else if (tsr_we) begin
         tsr_rd <= wr_data;
      end else if (tcr_view.f.en) begin
         tsr_rd <= tsr_rd + 1'b1;
      end
   end

   // Match on the low slice with interrupt enable
   assign irq_set = (tsr_rd[TSC_CNT_DW-1:0] == tcr_view.f.cnt) & tcr_view.f.i;
   // Writing TCR with p low acknowledges
   assign irq_clr = tcr_we & ~tcr_wr.f.p;

   // Interrupt flag, clear dominant
   always_ff @(posedge clk) begin
      if (rst) begin
         tsc_irq <= 1'b0;
      end else if (irq_clr) begin
         tsc_irq <= 1'b0;
      end else if (irq_set) begin
         tsc_irq <= 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: hw/irq_ctrl.sv
// Interrupt controller: external line synchronizers, IMR, IRR and CPU interrupt
`timescale 1ns/1ps
`default_nettype none

module irq_ctrl
   import ncpu_pkg::*;
(
   input  logic                clk,
   input  logic                rst,
   // Asynchronous level lines
   input  logic [NEXT_IRQ-1:0] ext_irq,
   input  logic                tsc_irq,
   // IMR write from the MSR port
   input  logic                imr_we,
   input  logic [NCPU_DW-1:0]  wr_data,
   output logic [NCPU_DW-1:0]  imr_rd,
   output logic [NIRQ-1:0]     irr_rd,
   output logic                cpu_irq
);

   // Two-flop synchronizer per line
   logic [NEXT_IRQ-1:0] sync_q1;
   logic [NEXT_IRQ-1:0] sync_q2;

   // Mask, one bit per line, set means enabled
   logic [NIRQ-1:0]     imr_r;

   // Request vector
   logic [NIRQ-1:0]     irr;

   // First stage may go metastable
   // second stage is the clean copy
   always_ff @(posedge clk) begin
      if (rst) begin
         sync_q1 <= '0;
         sync_q2 <= '0;
      end else begin
         sync_q1 <= ext_irq;
         sync_q2 <= sync_q1;
      end
   end

   // TSC at its own slot, external lines stacked above it
   always_comb begin
      irr                          = '0;
      irr[IRQ_TSC]                 = tsc_irq;
      irr[NIRQ-1:IRQ_TSC+1]        = sync_q2;
   end

   assign irr_rd = irr;

   // Mask register
   // only the low NIRQ bits of a write are kept
   always_ff @(posedge clk) begin
      if (rst) begin
         imr_r <= '0;
      end else if (imr_we) begin
         imr_r <= wr_data[NIRQ-1:0];
      end
   end

   // Zero-extended read back
   assign imr_rd = {{(NCPU_DW-NIRQ){1'b0}}, imr_r};

   // Combined request, registered toward the CPU
   // ext_irq reaches here after three edges, tsc_irq after one
   always_ff @(posedge clk) begin
      if (rst) begin
         cpu_irq <= 1'b0;
      end else begin
         cpu_irq <= |(irr & imr_r);
      end
   end

endmodule

`default_nettype wire

// File: hw/ncpu_timer_top.sv
// Timer subsystem top: MSR port, timestamp counter and interrupt controller
`timescale 1ns/1ps
`default_nettype none

module ncpu_timer_top
   import ncpu_pkg::*;
(
   input  logic                clk,
   input  logic                rst,
   // MSR access port
   input  logic                msr_req,
   input  logic                msr_we,
   input  logic [MSR_AW-1:0]   msr_addr,
   input  logic [NCPU_DW-1:0]  msr_wdata,
   output logic                msr_ack,
   output logic [NCPU_DW-1:0]  msr_rdata,
   // Interrupts
   input  logic [NEXT_IRQ-1:0] ext_irq,
   output logic                cpu_irq
);

   // Shared write data and per-register strobes
   logic [NCPU_DW-1:0] wr_data;
   logic               tsr_we;
   logic               tcr_we;
   logic               imr_we;

   // Read values back to the port
   logic [NCPU_DW-1:0] tsr_rd;
   logic [NCPU_DW-1:0] tcr_rd;
   logic [NCPU_DW-1:0] imr_rd;
   logic [NIRQ-1:0]    irr_rd;

   // Counter interrupt into the controller
   logic               tsc_irq;

   msr_port msr_port_inst (
      .clk     (clk),
      .rst     (rst),
      .req     (msr_req),
      .we      (msr_we),
      .addr    (msr_addr),
      .wdata   (msr_wdata),
      .ack     (msr_ack),
      .rdata   (msr_rdata),
      .wr_data (wr_data),
      .tsr_we  (tsr_we),
      .tcr_we  (tcr_we),
      .imr_we  (imr_we),
      .tsr_rd  (tsr_rd),
      .tcr_rd  (tcr_rd),
      .imr_rd  (imr_rd),
      .irr_rd  (irr_rd)
   );

   tsc tsc_inst (
      .clk     (clk),
      .rst     (rst),
      .tsr_we  (tsr_we),
      .tcr_we  (tcr_we),
      .wr_data (wr_data),
      .tsr_rd  (tsr_rd),
      .tcr_rd  (tcr_rd),
      .tsc_irq (tsc_irq)
   );

   irq_ctrl irq_ctrl_inst (
      .clk     (clk),
      .rst     (rst),
      .ext_irq (ext_irq),
      .tsc_irq (tsc_irq),
      .imr_we  (imr_we),
      .wr_data (wr_data),
      .imr_rd  (imr_rd),
      .irr_rd  (irr_rd),
      .cpu_irq (cpu_irq)
   );

endmodule

`default_nettype wire

// File: bench/tb_clock.sv
// Free-running testbench clock with a 100 ns period
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
   output logic clk
);

   // Half of the 100 ns period
   localparam int HALF_PERIOD = 50;

   initial begin
      clk = 1'b0;
      forever begin
         #(HALF_PERIOD) clk = ~clk;
      end
   end

endmodule

`default_nettype wire

// File: bench/tb_ncpu_timer.sv
// Timer subsystem testbench: MSR access tasks, stimulus table, xorshift data and checks
`timescale 1ns/1ps
`default_nettype none

module tb_ncpu_timer
   import ncpu_pkg::*;
();

   // Row operations of the stimulus table
   localparam logic [1:0] OP_WR  = 2'd0;
   localparam logic [1:0] OP_RD  = 2'd1;
   localparam logic [1:0] OP_IRQ = 2'd2;

   // Cycles allowed for each handshake phase
   localparam int ACK_LIMIT = 20;

   logic                clk;
   logic                rst;
   logic                msr_req;
   logic                msr_we;
   logic [MSR_AW-1:0]   msr_addr;
   logic [NCPU_DW-1:0]  msr_wdata;
   logic                msr_ack;
   logic [NCPU_DW-1:0]  msr_rdata;
   logic [NEXT_IRQ-1:0] ext_irq;
   logic                cpu_irq;

   // Stimulus table held as one queue per column
   logic [1:0]          row_op[$];
   logic [MSR_AW-1:0]   row_addr[$];
   logic [NCPU_DW-1:0]  row_data[$];
   logic [NCPU_DW-1:0]  row_exp[$];
   logic [NEXT_IRQ-1:0] row_ext[$];

   int unsigned         value_errors;
   int unsigned         timeout_errors;
   logic [31:0]         rng_state;
   // Mask as last written by the testbench
   logic [NIRQ-1:0]     imr_model;

   tb_clock tb_clock_inst (
      .clk (clk)
   );

   ncpu_timer_top ncpu_timer_top_inst (
      .clk       (clk),
      .rst       (rst),
      .msr_req   (msr_req),
      .msr_we    (msr_we),
      .msr_addr  (msr_addr),
      .msr_wdata (msr_wdata),
      .msr_ack   (msr_ack),
      .msr_rdata (msr_rdata),
      .ext_irq   (ext_irq),
      .cpu_irq   (cpu_irq)
   );

   // Xorshift32 step
   function automatic logic [31:0] next_random();
      logic [31:0] x;
      x = rng_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng_state = x;
      return x;
   endfunction

   // External lines shifted above the idle TSC slot
   function automatic logic [NIRQ-1:0] request_vector(input logic [NEXT_IRQ-1:0] ext);
      return {ext, 1'b0};
   endfunction

   function automatic string reg_name(input logic [MSR_AW-1:0] a);
      case (a)
         MSR_TSR: return "msr_rdata (TSR)";
         MSR_TCR: return "msr_rdata (TCR)";
         MSR_IMR: return "msr_rdata (IMR)";
         MSR_IRR: return "msr_rdata (IRR)";
         default: return "msr_rdata (unmapped)";
      endcase
   endfunction

   task automatic compare_word(input string name, input logic [NCPU_DW-1:0] expected,
                               input logic [NCPU_DW-1:0] actual);
      if (actual !== expected) begin
         value_errors++;
         $display("error at %0t ns: %s expected %h actual %h", $time, name, expected, actual);
      end
   endtask

   task automatic add_row(input logic [1:0] op, input logic [MSR_AW-1:0] addr,
                          input logic [NCPU_DW-1:0] data, input logic [NCPU_DW-1:0] exp,
                          input logic [NEXT_IRQ-1:0] ext);
      row_op.push_back(op);
      row_addr.push_back(addr);
      row_data.push_back(data);
      row_exp.push_back(exp);
      row_ext.push_back(ext);
   endtask

   // Four-phase access entered and left just after a falling edge
   // hold keeps req up for extra cycles once ack is seen
   task automatic msr_access(input logic write, input logic [MSR_AW-1:0] addr,
                             input logic [NCPU_DW-1:0] data, input int hold,
                             output logic [NCPU_DW-1:0] rd);
      int                 n;
      logic [NCPU_DW-1:0] first;
      msr_req   = 1'b1;
      msr_we    = write;
      msr_addr  = addr;
      msr_wdata = data;
      n = 0;
      while (msr_ack !== 1'b1 && n < ACK_LIMIT) begin
         @(negedge clk);
         n++;
      end
      if (msr_ack !== 1'b1) begin
         timeout_errors++;
         $display("handshake timeout: ack never rose for address %h", addr);
      end
      rd    = msr_rdata;
      first = msr_rdata;
      for (int k = 0; k < hold; k++) begin
         @(negedge clk);
         compare_word("msr_ack", 1'b1, msr_ack);
         compare_word("msr_rdata", first, msr_rdata);
      end
      msr_req = 1'b0;
      n = 0;
      while (msr_ack !== 1'b0 && n < ACK_LIMIT) begin
         @(negedge clk);
         n++;
      end
      if (msr_ack !== 1'b0) begin
         timeout_errors++;
         $display("handshake timeout: ack stayed high after req fell, address %h", addr);
      end else if (hold > 0) begin
         // Release takes exactly one edge
         compare_word("msr_ack fall cycles", 1, n);
      end
   endtask

   task automatic msr_write(input logic [MSR_AW-1:0] addr, input logic [NCPU_DW-1:0] data);
      logic [NCPU_DW-1:0] unused;
      msr_access(1'b1, addr, data, 0, unused);
   endtask

   task automatic msr_read(input logic [MSR_AW-1:0] addr, output logic [NCPU_DW-1:0] rd);
      msr_access(1'b0, addr, '0, 0, rd);
   endtask

   task automatic wait_cpu_irq(input logic level, input int limit);
      int n;
      n = 0;
      while (cpu_irq !== level && n < limit) begin
         @(negedge clk);
         n++;
      end
      if (cpu_irq !== level) begin
         timeout_errors++;
         $display("timeout: cpu_irq did not reach %0b within %0d cycles", level, limit);
      end
   endtask

   // Reset rows 0..3 followed by the compare interrupt and the line and mask rows
   task automatic fill_table();
      add_row(OP_RD, MSR_TSR, 32'h0, 32'h0, 7'h00);
      add_row(OP_RD, MSR_TCR, 32'h0, 32'h0, 7'h00);
      add_row(OP_RD, MSR_IMR, 32'h0, 32'h0, 7'h00);
      add_row(OP_RD, MSR_IRR, 32'h0, 32'h0, 7'h00);
      // Compare value 40 with i and en set and rsvd and rb1 written high
      add_row(OP_WR, MSR_TSR, 32'h0, 32'h0, 7'h00);
      add_row(OP_WR, MSR_IMR, 32'h1, 32'h0, 7'h00);
      add_row(OP_WR, MSR_TCR, 32'hFB00_0028, 32'h0, 7'h00);
      add_row(OP_IRQ, MSR_TSR, 32'd100, 32'h1, 7'h00);
      add_row(OP_RD, MSR_TCR, 32'h0, 32'h0F00_0028, 7'h00);
      // Acknowledge with p and i low
      add_row(OP_WR, MSR_TCR, 32'h0100_0028, 32'h0, 7'h00);
      add_row(OP_IRQ, MSR_TSR, 32'd20, 32'h0, 7'h00);
      add_row(OP_WR, MSR_TCR, 32'h0, 32'h0, 7'h00);
      // Lines and mask
      add_row(OP_WR, MSR_IMR, 32'hFF, 32'h0, 7'h00);
      add_row(OP_RD, MSR_IRR, 32'h0, 32'h00, 7'h00);
      add_row(OP_RD, MSR_IRR, 32'h0, 32'h02, 7'h01);
      add_row(OP_RD, MSR_IRR, 32'h0, 32'hAA, 7'h55);
      add_row(OP_WR, MSR_IMR, 32'h54, 32'h0, 7'h55);
      add_row(OP_IRQ, MSR_TSR, 32'd20, 32'h0, 7'h55);
      add_row(OP_RD, MSR_IRR, 32'h0, 32'h54, 7'h2A);
      add_row(OP_RD, MSR_IRR, 32'h0, 32'h80, 7'h40);
      add_row(OP_WR, MSR_IMR, 32'h80, 32'h0, 7'h40);
      add_row(OP_IRQ, MSR_TSR, 32'd20, 32'h1, 7'h40);
      add_row(OP_RD, MSR_IRR, 32'h0, 32'hFE, 7'h7F);
      add_row(OP_RD, MSR_IRR, 32'h0, 32'h00, 7'h00);
      add_row(OP_WR, MSR_IMR, 32'h0, 32'h0, 7'h00);
   endtask

   task automatic apply_rows(input int first, input int last);
      logic [NCPU_DW-1:0] rd;
      logic               want;
      for (int r = first; r <= last; r++) begin
         if (row_ext[r] !== ext_irq) begin
            ext_irq = row_ext[r];
            // Two synchronizer flops and the output register
            repeat (3) @(posedge clk);
            @(negedge clk);
            want = |(request_vector(ext_irq) & imr_model);
            compare_word("cpu_irq", want, cpu_irq);
         end
         case (row_op[r])
            OP_WR: begin
               msr_write(row_addr[r], row_data[r]);
               if (row_addr[r] == MSR_IMR) begin
                  imr_model = row_data[r][NIRQ-1:0];
               end
            end
            OP_RD: begin
               msr_read(row_addr[r], rd);
               compare_word(reg_name(row_addr[r]), row_exp[r], rd);
            end
            default: wait_cpu_irq(row_exp[r][0], row_data[r]);
         endcase
      end
   endtask

   initial begin
      logic [NCPU_DW-1:0] r1;
      logic [NCPU_DW-1:0] r2;
      logic [NCPU_DW-1:0] r3;
      logic [NCPU_DW-1:0] a;
      logic [NCPU_DW-1:0] b;
      rst            = 1'b1;
      msr_req        = 1'b0;
      msr_we         = 1'b0;
      msr_addr       = '0;
      msr_wdata      = '0;
      ext_irq        = '0;
      value_errors   = 0;
      timeout_errors = 0;
      rng_state      = 32'h26a7_377c;
      imr_model      = '0;
      fill_table();
      repeat (8) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      compare_word("msr_ack", 1'b0, msr_ack);
      compare_word("cpu_irq", 1'b0, cpu_irq);
      apply_rows(0, 3);

      // Random read back with counting stopped
      r1 = next_random();
      msr_write(MSR_TSR, r1);
      msr_read(MSR_TSR, a);
      compare_word("msr_rdata (TSR)", r1, a);
      r2 = next_random();
      msr_write(MSR_IMR, r2);
      imr_model = r2[NIRQ-1:0];
      msr_read(MSR_IMR, a);
      compare_word("msr_rdata (IMR)", r2 & 32'h0000_00FF, a);
      // IRR and unmapped writes are dropped
      r3 = next_random();
      msr_write(MSR_IRR, r3);
      msr_write(4'h9, r3);
      msr_write(4'hF, ~r3);
      msr_read(MSR_IRR, a);
      compare_word("msr_rdata (IRR)", 32'h0, a);
      msr_read(MSR_TSR, a);
      compare_word("msr_rdata (TSR)", r1, a);
      msr_read(MSR_IMR, a);
      compare_word("msr_rdata (IMR)", r2 & 32'h0000_00FF, a);
      msr_read(MSR_TCR, a);
      compare_word("msr_rdata (TCR)", 32'h0, a);
      msr_read(4'h9, a);
      compare_word("msr_rdata (unmapped)", 32'h0, a);
      msr_read(4'hC, a);
      compare_word("msr_rdata (unmapped)", 32'h0, a);

      // Counting switched on and off again
      // Every access spans two edges to ack and one to release
      // The enabling strobe edge already counts
      // A read returns the count after its first edge
      msr_write(MSR_TSR, 32'h0000_1000);
      msr_write(MSR_TCR, 32'h0100_0000);
      msr_read(MSR_TSR, a);
      msr_read(MSR_TSR, b);
      compare_word("msr_rdata (TSR)", 32'h0000_1003, a);
      compare_word("msr_rdata (TSR)", 32'h0000_1006, b);
      // Counting stops with the strobe edge of this write
      msr_write(MSR_TCR, 32'h0);
      msr_read(MSR_TSR, a);
      msr_read(MSR_TSR, b);
      compare_word("msr_rdata (TSR)", 32'h0000_1009, a);
      compare_word("msr_rdata (TSR)", 32'h0000_1009, b);

      apply_rows(4, row_op.size() - 1);

      // Long req on a running counter holds rdata still
      msr_write(MSR_TSR, 32'h0000_2000);
      msr_write(MSR_TCR, 32'h0100_0000);
      msr_access(1'b0, MSR_TSR, '0, 5, a);
      compare_word("msr_rdata (TSR)", 32'h0000_2003, a);
      msr_write(MSR_TCR, 32'h0);

      $display("closing: %0d value errors, %0d timeouts", value_errors, timeout_errors);
      if (value_errors == 0 && timeout_errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: ncpu_timer.f
hw/ncpu_pkg.sv
hw/msr_port.sv
hw/tsc.sv
hw/irq_ctrl.sv
hw/ncpu_timer_top.sv
bench/tb_clock.sv
bench/tb_ncpu_timer.sv
